//--- common/roach_pkg.sv
package roach_pkg;

  // Register bus geometry
  localparam int ADDR_W = 2;
  localparam int DATA_W = 32;

  // Register map
  localparam logic [ADDR_W-1:0] REG_BOARD_ID  = 2'd0;
  localparam logic [ADDR_W-1:0] REG_SCRATCH   = 2'd1;
  localparam logic [ADDR_W-1:0] REG_STATUS    = 2'd2; // Bit 0 lock, bit 1 idelay ready
  localparam logic [ADDR_W-1:0] REG_AUX_COUNT = 2'd3;

  // Read-only board identification
  localparam logic [DATA_W-1:0] BOARD_ID = 32'h0A0C_0001;

  // Stand-in for the MMCM lock time
  localparam int LOCK_CYCLES = 16;

  // Stand-in for IDELAYCTRL calibration
  localparam int IDELAY_CYCLES = 8;

  // Aux activity measurement
  localparam int GATE_CYCLES = 64; // Length of one counting gate
  localparam int COUNT_W     = 16; // Saturating count width

endpackage

//--- common/reg_bus_if.sv
interface reg_bus_if;

  logic                         req;   // Held until done is seen
  logic                         we;
  logic [roach_pkg::ADDR_W-1:0] addr;
  logic [roach_pkg::DATA_W-1:0] wdata;
  logic [roach_pkg::DATA_W-1:0] rdata; // Valid with done
  logic                         done;  // One-cycle completion pulse

  modport master (
    output req,
    output we,
    output addr,
    output wdata,
    input  rdata,
    input  done
  );

  modport slave (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    output rdata,
    output done
  );

endinterface

//--- infrastructure/roach_infrastructure.sv
module roach_infrastructure (
  input  logic sys_clk,
  input  logic reset,
  input  logic idelay_rst,
  output logic sys_clk_lock,
  output logic op_power_on_rst,
  output logic idelay_rdy
);

  logic [$clog2(roach_pkg::LOCK_CYCLES+1)-1:0]   lock_cnt;
  logic [$clog2(roach_pkg::IDELAY_CYCLES+1)-1:0] dly_cnt;

  // MMCM lock model that holds once locked
  always_ff @(posedge sys_clk) begin
    if (reset) begin
      lock_cnt     <= '0;
      sys_clk_lock <= 1'b0;
    end else if (!sys_clk_lock) begin
      if (lock_cnt == roach_pkg::LOCK_CYCLES) begin
        sys_clk_lock <= 1'b1;
      end else begin
        lock_cnt <= lock_cnt + 1'b1;
      end
    end
  end

  // Board logic stays in reset until the clock is stable
  assign op_power_on_rst = ~sys_clk_lock;

  // IDELAYCTRL calibration model
  always_ff @(posedge sys_clk) begin
    if (reset || idelay_rst) begin
      dly_cnt    <= '0;
      idelay_rdy <= 1'b0;
    end else if (sys_clk_lock && !idelay_rdy) begin
      if (dly_cnt == roach_pkg::IDELAY_CYCLES) begin
        idelay_rdy <= 1'b1;
      end else begin
        dly_cnt <= dly_cnt + 1'b1; // Calibrating
      end
    end
  end

endmodule

//--- hdl/epb_port.sv
module epb_port (
  input  logic                         sys_clk,
  input  logic                         reset,
  input  logic                         epb_stb,
  input  logic                         epb_we,
  input  logic [roach_pkg::ADDR_W-1:0] epb_addr,
  input  logic [roach_pkg::DATA_W-1:0] epb_wdata,
  output logic                         epb_ack,
  output logic [roach_pkg::DATA_W-1:0] epb_rdata,
  reg_bus_if.master                    bus
);

  logic                         pend_we;
  logic [roach_pkg::ADDR_W-1:0] pend_addr;
  logic [roach_pkg::DATA_W-1:0] pend_wdata;

  // Request doubles as the busy flag
  always_ff @(posedge sys_clk) begin
    if (reset) begin
      bus.req <= 1'b0;
      epb_ack <= 1'b0;
    end else begin
      epb_ack <= 1'b0;
      if (!bus.req && epb_stb) begin
        bus.req <= 1'b1; // Host transaction pending
      end else if (bus.req && bus.done) begin
        bus.req <= 1'b0;
        epb_ack <= 1'b1;
      end
    end
  end

  // Transaction fields captured with the strobe
  always_ff @(posedge sys_clk) begin
    if (!bus.req && epb_stb) begin
      pend_we    <= epb_we;
      pend_addr  <= epb_addr;
      pend_wdata <= epb_wdata;
    end
    if (bus.req && bus.done) begin
      epb_rdata <= bus.rdata; // Shown to host with the ack
    end
  end

  assign bus.we    = pend_we;
  assign bus.addr  = pend_addr;
  assign bus.wdata = pend_wdata;

endmodule

//--- hdl/aux_clk_counter.sv
module aux_clk_counter (
  input  logic      sys_clk,
  input  logic      reset,
  input  logic      aux_tick,
  reg_bus_if.master bus
);

  logic [$clog2(roach_pkg::GATE_CYCLES)-1:0] gate_cnt;
  logic [roach_pkg::COUNT_W-1:0]             run_cnt;
  logic [roach_pkg::COUNT_W-1:0]             run_next;
  logic [roach_pkg::COUNT_W-1:0]             pend_cnt;
  logic                                      pend_vld;
  logic [roach_pkg::COUNT_W-1:0]             post_cnt;
  logic                                      gate_end;

  assign gate_end = (gate_cnt == roach_pkg::GATE_CYCLES - 1);
  // Saturate rather than wrap
  assign run_next = (aux_tick && run_cnt != '1) ? run_cnt + 1'b1 : run_cnt;

  always_ff @(posedge sys_clk) begin
    if (reset) begin
      gate_cnt <= '0;
      run_cnt  <= '0;
      pend_vld <= 1'b0;
      bus.req  <= 1'b0;
    end else begin
      gate_cnt <= gate_end ? '0 : gate_cnt + 1'b1;
      run_cnt  <= gate_end ? '0 : run_next; // Tick in the last cycle still counts
      if (bus.req && bus.done) begin
        bus.req <= 1'b0;
      end else if (!bus.req && pend_vld) begin
        bus.req  <= 1'b1;
        pend_vld <= 1'b0;
      end
      if (gate_end) begin
        pend_vld <= 1'b1; // Newest result wins
      end
    end
  end

  // Count words
  always_ff @(posedge sys_clk) begin
    if (gate_end) pend_cnt <= run_next;
    if (!bus.req && pend_vld) post_cnt <= pend_cnt; // Frozen while on the bus
  end

  assign bus.we    = 1'b1;
  assign bus.addr  = roach_pkg::REG_AUX_COUNT;
  assign bus.wdata = {{(roach_pkg::DATA_W-roach_pkg::COUNT_W){1'b0}}, post_cnt};

endmodule

//--- hdl/reg_arbiter.sv
module reg_arbiter (
  input  logic      sys_clk,
  input  logic      reset,
  reg_bus_if.slave  epb,
  reg_bus_if.slave  cnt,
  reg_bus_if.master mem
);

  logic busy;    // Bus owned until done
  logic gnt_epb; // High when the EPB port owns the bus

  always_ff @(posedge sys_clk) begin
    if (reset) begin
      busy    <= 1'b0;
      gnt_epb <= 1'b0;
    end else if (!busy) begin
      // Host wins each idle decision
      if (epb.req) begin
        busy    <= 1'b1;
        gnt_epb <= 1'b1;
      end else if (cnt.req) begin
        busy    <= 1'b1;
        gnt_epb <= 1'b0;
      end
    end else if (mem.done) begin
      busy <= 1'b0; // Requests rechecked next cycle
    end
  end

  // Forward the owner onto the shared bus
  always_comb begin
    if (gnt_epb) begin
      mem.req   = busy & epb.req;
      mem.we    = epb.we;
      mem.addr  = epb.addr;
      mem.wdata = epb.wdata;
    end else begin
      mem.req   = busy & cnt.req;
      mem.we    = cnt.we;
      mem.addr  = cnt.addr;
      mem.wdata = cnt.wdata;
    end
  end

  // Completion goes back to the owner only
  assign epb.done  = mem.done & busy & gnt_epb;
  assign cnt.done  = mem.done & busy & ~gnt_epb;
  assign epb.rdata = gnt_epb ? mem.rdata : '0;
  assign cnt.rdata = gnt_epb ? '0 : mem.rdata;

endmodule

//--- hdl/sys_regfile.sv
module sys_regfile (
  input  logic     sys_clk,
  input  logic     reset,
  input  logic     sys_clk_lock,
  input  logic     idelay_rdy,
  reg_bus_if.slave bus
);

  logic [roach_pkg::DATA_W-1:0] scratch;
  logic [roach_pkg::DATA_W-1:0] aux_count;
  logic [roach_pkg::DATA_W-1:0] rd_word;
  logic                         take; // New request this cycle

  // Req is still high during the done cycle
  assign take = bus.req & ~bus.done;

  always_comb begin
    case (bus.addr)
      roach_pkg::REG_BOARD_ID: rd_word = roach_pkg::BOARD_ID;
      roach_pkg::REG_SCRATCH:  rd_word = scratch;
      roach_pkg::REG_STATUS:
        rd_word = {{(roach_pkg::DATA_W-2){1'b0}}, idelay_rdy, sys_clk_lock};
      default:                 rd_word = aux_count;
    endcase
  end

  always_ff @(posedge sys_clk) begin
    if (reset) begin
      bus.done  <= 1'b0;
      scratch   <= '0;
      aux_count <= '0;
    end else begin
      bus.done <= take;
      if (take && bus.we) begin
        // ID and status are read-only
        case (bus.addr)
          roach_pkg::REG_SCRATCH:   scratch   <= bus.wdata;
          roach_pkg::REG_AUX_COUNT: aux_count <= bus.wdata;
          default: ;
        endcase
      end
    end
  end

  // Registered read data
  always_ff @(posedge sys_clk) begin
    if (take) begin
      bus.rdata <= rd_word;
    end
  end

endmodule

//--- hdl/roach_sys_top.sv
module roach_sys_top (
  input  logic                         sys_clk,
  input  logic                         reset,
  input  logic                         idelay_rst,
  input  logic                         aux_tick,
  input  logic                         epb_stb,
  input  logic                         epb_we,
  input  logic [roach_pkg::ADDR_W-1:0] epb_addr,
  input  logic [roach_pkg::DATA_W-1:0] epb_wdata,
  output logic                         sys_clk_lock,
  output logic                         op_power_on_rst,
  output logic                         idelay_rdy,
  output logic                         epb_ack,
  output logic [roach_pkg::DATA_W-1:0] epb_rdata
);

  logic blk_rst; // Held until the clock locks

  reg_bus_if epb_bus ();
  reg_bus_if cnt_bus ();
  reg_bus_if reg_bus ();

  assign blk_rst = reset | op_power_on_rst;

  roach_infrastructure u_infra (
    .sys_clk         (sys_clk),
    .reset           (reset),
    .idelay_rst      (idelay_rst),
    .sys_clk_lock    (sys_clk_lock),
    .op_power_on_rst (op_power_on_rst),
    .idelay_rdy      (idelay_rdy)
  );

  epb_port u_epb (
    .sys_clk   (sys_clk),
    .reset     (blk_rst),
    .epb_stb   (epb_stb),
    .epb_we    (epb_we),
    .epb_addr  (epb_addr),
    .epb_wdata (epb_wdata),
    .epb_ack   (epb_ack),
    .epb_rdata (epb_rdata),
    .bus       (epb_bus.master)
  );

  aux_clk_counter u_aux_cnt (
    .sys_clk  (sys_clk),
    .reset    (blk_rst),
    .aux_tick (aux_tick),
    .bus      (cnt_bus.master)
  );

  reg_arbiter u_arb (
    .sys_clk (sys_clk),
    .reset   (blk_rst),
    .epb     (epb_bus.slave),
    .cnt     (cnt_bus.slave),
    .mem     (reg_bus.master)
  );

  sys_regfile u_regs (
    .sys_clk      (sys_clk),
    .reset        (blk_rst),
    .sys_clk_lock (sys_clk_lock),
    .idelay_rdy   (idelay_rdy),
    .bus          (reg_bus.slave)
  );

endmodule

//--- verif/tb_roach_sys.sv
module tb_roach_sys;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int SEED       = 32'h4a8;
  localparam int MAX_CYCLES = 4000; // About four times the full sequence
  localparam int TICK_SPACE = 4;    // 16 ticks in every 64-cycle gate

  logic                         sys_clk = 1'b0;
  logic                         reset;
  logic                         idelay_rst;
  logic                         aux_tick = 1'b0;
  logic                         epb_stb;
  logic                         epb_we;
  logic [roach_pkg::ADDR_W-1:0] epb_addr;
  logic [roach_pkg::DATA_W-1:0] epb_wdata;
  logic                         sys_clk_lock;
  logic                         op_power_on_rst;
  logic                         idelay_rdy;
  logic                         epb_ack;
  logic [roach_pkg::DATA_W-1:0] epb_rdata;

  int cyc = 0;
  int errors = 0;
  int checks = 0;
  int tests_run = 0;
  int tests_bad = 0;
  int test_err0;
  int lock_cyc;
  string cur_name;
  logic tick_en;
  logic lock_lvl;                              // Expected lock level
  logic rdy_lvl;                               // Expected idelay ready level
  logic [roach_pkg::DATA_W-1:0] shadow_scratch;
  logic [roach_pkg::DATA_W-1:0] aux_exp;
  logic [roach_pkg::ADDR_W-1:0] addr_q[$];
  logic [roach_pkg::DATA_W-1:0] got_q[$];
  logic [roach_pkg::DATA_W-1:0] want_q[$];

  roach_sys_top u_dut (
    .sys_clk         (sys_clk),
    .reset           (reset),
    .idelay_rst      (idelay_rst),
    .aux_tick        (aux_tick),
    .epb_stb         (epb_stb),
    .epb_we          (epb_we),
    .epb_addr        (epb_addr),
    .epb_wdata       (epb_wdata),
    .sys_clk_lock    (sys_clk_lock),
    .op_power_on_rst (op_power_on_rst),
    .idelay_rdy      (idelay_rdy),
    .epb_ack         (epb_ack),
    .epb_rdata       (epb_rdata)
  );

  always #10 sys_clk = ~sys_clk;

  always @(posedge sys_clk) begin
    cyc      <= cyc + 1;
    aux_tick <= tick_en && (cyc % TICK_SPACE == 0); // Aux clock seen as a tick
  end

  always @(posedge sys_clk) begin
    if (cyc >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("tests failed");
      $finish;
    end
  end

  // Expected register contents
  function automatic logic [roach_pkg::DATA_W-1:0] ref_read(
    input logic [roach_pkg::ADDR_W-1:0] addr
  );
    case (addr)
      roach_pkg::REG_BOARD_ID: return roach_pkg::BOARD_ID;
      roach_pkg::REG_SCRATCH:  return shadow_scratch;
      roach_pkg::REG_STATUS:   return {{(roach_pkg::DATA_W-2){1'b0}}, rdy_lvl, lock_lvl};
      default:                 return aux_exp;
    endcase
  endfunction

  always @(posedge sys_clk) begin : compare_rsp
    logic [roach_pkg::ADDR_W-1:0] a;
    logic [roach_pkg::DATA_W-1:0] got;
    logic [roach_pkg::DATA_W-1:0] want;
    while (got_q.size() > 0) begin
      a    = addr_q.pop_front();
      got  = got_q.pop_front();
      want = want_q.pop_front();
      checks++;
      assert (got === want) else begin
        $display("ERROR %0t: epb_rdata (addr %0d) got %h expected %h", $time, a, got, want);
        errors++;
      end
    end
  end

  task automatic check_int(input string name, input int got, input int want);
    checks++;
    assert (got == want) else begin
      $display("ERROR %0t: %s got %0d expected %0d", $time, name, got, want);
      errors++;
    end
  endtask

  // Count cycles until lock or ready is seen high
  task automatic measure_rise(input bit use_rdy, output int n);
    int start;
    start = cyc;
    while ((use_rdy ? idelay_rdy : sys_clk_lock) !== 1'b1) @(negedge sys_clk);
    n = cyc - start;
  endtask

  task automatic epb_xfer(input logic we, input logic [roach_pkg::ADDR_W-1:0] addr,
                          input logic [roach_pkg::DATA_W-1:0] wdata,
                          output logic [roach_pkg::DATA_W-1:0] rdata);
    @(posedge sys_clk);
    epb_stb   <= 1'b1;
    epb_we    <= we;
    epb_addr  <= addr;
    epb_wdata <= wdata;
    @(posedge sys_clk);
    epb_stb <= 1'b0; // One-cycle strobe
    do @(negedge sys_clk); while (epb_ack !== 1'b1);
    rdata = epb_rdata;
  endtask

  task automatic epb_read(input logic [roach_pkg::ADDR_W-1:0] addr);
    logic [roach_pkg::DATA_W-1:0] d;
    epb_xfer(1'b0, addr, '0, d);
    addr_q.push_back(addr);
    got_q.push_back(d);
    want_q.push_back(ref_read(addr));
  endtask

  task automatic epb_write(input logic [roach_pkg::ADDR_W-1:0] addr,
                           input logic [roach_pkg::DATA_W-1:0] data);
    logic [roach_pkg::DATA_W-1:0] d;
    epb_xfer(1'b1, addr, data, d);
    if (addr == roach_pkg::REG_SCRATCH) shadow_scratch = data;
  endtask

  task automatic begin_test(input string name);
    cur_name  = name;
    test_err0 = errors;
  endtask

  task automatic end_test();
    while (got_q.size() != 0) @(negedge sys_clk); // Let compares drain
    tests_run++;
    if (errors == test_err0) begin
      $display("test %0d %s: ok", tests_run, cur_name);
    end else begin
      tests_bad++;
      $display("test %0d %s: FAIL with %0d errors", tests_run, cur_name, errors - test_err0);
    end
  endtask

  initial begin
    int n;
    logic [31:0] rnd;
    logic [roach_pkg::ADDR_W-1:0] rd_addr;
    void'($urandom(SEED));
    reset          = 1'b1;
    idelay_rst     = 1'b1;
    tick_en        = 1'b1;
    epb_stb        = 1'b0;
    epb_we         = 1'b0;
    epb_addr       = '0;
    epb_wdata      = '0;
    lock_lvl       = 1'b0;
    rdy_lvl        = 1'b0;
    shadow_scratch = '0;
    aux_exp        = '0;

    begin_test("power-on lock");
    repeat (4) @(posedge sys_clk);
    @(negedge sys_clk);
    check_int("op_power_on_rst", op_power_on_rst, 1);
    check_int("sys_clk_lock", sys_clk_lock, 0);
    check_int("idelay_rdy", idelay_rdy, 0);
    check_int("epb_ack", epb_ack, 0);
    @(posedge sys_clk);
    reset <= 1'b0;
    @(posedge sys_clk); // First edge with reset low
    @(negedge sys_clk);
    measure_rise(1'b0, n);
    check_int("cycles to sys_clk_lock", n, roach_pkg::LOCK_CYCLES);
    check_int("op_power_on_rst", op_power_on_rst, 0);
    lock_lvl = 1'b1;
    lock_cyc = cyc;
    end_test();

    begin_test("idelay ready and status");
    @(posedge sys_clk);
    idelay_rst <= 1'b0;
    @(posedge sys_clk);
    @(negedge sys_clk);
    measure_rise(1'b1, n);
    check_int("cycles to idelay_rdy", n, roach_pkg::IDELAY_CYCLES);
    rdy_lvl = 1'b1;
    epb_read(roach_pkg::REG_STATUS);
    @(posedge sys_clk);
    idelay_rst <= 1'b1;
    @(posedge sys_clk);
    @(negedge sys_clk);
    check_int("idelay_rdy", idelay_rdy, 0);
    rdy_lvl = 1'b0;
    epb_read(roach_pkg::REG_STATUS); // Held in calibration reset
    @(posedge sys_clk);
    idelay_rst <= 1'b0;
    @(posedge sys_clk);
    @(negedge sys_clk);
    measure_rise(1'b1, n);
    check_int("cycles to idelay_rdy", n, roach_pkg::IDELAY_CYCLES);
    rdy_lvl = 1'b1;
    epb_read(roach_pkg::REG_STATUS);
    end_test();

    begin_test("register access");
    epb_read(roach_pkg::REG_BOARD_ID);
    epb_write(roach_pkg::REG_BOARD_ID, 32'hFFFF_FFFF);
    epb_read(roach_pkg::REG_BOARD_ID);
    epb_write(roach_pkg::REG_STATUS, 32'h0000_0000);
    epb_read(roach_pkg::REG_STATUS);
    repeat (20) begin
      epb_write(roach_pkg::REG_SCRATCH, $urandom);
      epb_read(roach_pkg::REG_SCRATCH);
    end
    end_test();

    begin_test("aux count active");
    while (cyc < lock_cyc + 2 * roach_pkg::GATE_CYCLES + 8) @(negedge sys_clk);
    aux_exp = 16;
    epb_read(roach_pkg::REG_AUX_COUNT);
    end_test();

    begin_test("back-to-back reads");
    repeat (40) begin
      rnd     = $urandom;
      rd_addr = rnd[roach_pkg::ADDR_W-1:0];
      epb_read(rd_addr);
    end
    end_test();

    begin_test("aux count idle");
    tick_en = 1'b0;
    repeat (2 * roach_pkg::GATE_CYCLES + 16) @(negedge sys_clk);
    aux_exp = 0;
    epb_read(roach_pkg::REG_AUX_COUNT);
    end_test();

    $display("summary: %0d tests, %0d failing, %0d checks, %0d errors",
             tests_run, tests_bad, checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- build.f
common/roach_pkg.sv
common/reg_bus_if.sv
infrastructure/roach_infrastructure.sv
hdl/epb_port.sv
hdl/aux_clk_counter.sv
hdl/reg_arbiter.sv
hdl/sys_regfile.sv
hdl/roach_sys_top.sv
verif/tb_roach_sys.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_roach_sys -o sim_roach -f build.f

out=$(./obj_dir/sim_roach)
echo "$out"

echo "$out" | grep -qx "all tests passed" || exit 1
exit 0
